// ==== src/mmuPkg.sv ====
////////////////////////////////////////
// Shared constants of the Sv32 MMU
// Address widths and privilege codes
// Page types, PTE flags, PMP config fields
// Fixed physical memory attribute table
////////////////////////////////////////

package mmuPkg;

  // Virtual and physical address widths
  localparam int xLen   = 32;
  localparam int paBits = 34;

  // Privilege levels as in mstatus.MPP
  localparam logic [1:0] privU = 2'd0;
  localparam logic [1:0] privS = 2'd1;
  localparam logic [1:0] privM = 2'd3;

  // Page type written along with a TLB entry
  localparam logic pageKilo = 1'b0;
  localparam logic pageMega = 1'b1;

  // Sv32 PTE flag positions
  localparam int pteR = 1;
  localparam int pteW = 2;
  localparam int pteX = 3;
  localparam int pteU = 4;
  localparam int pteA = 6;
  localparam int pteD = 7;

  // PMP config byte, permission bits, A field and lock
  localparam int cfgR   = 0;
  localparam int cfgW   = 1;
  localparam int cfgX   = 2;
  localparam int cfgALo = 3;
  localparam int cfgL   = 7;
  localparam logic [1:0] pmpOff   = 2'd0;
  localparam logic [1:0] pmpTor   = 2'd1;
  localparam logic [1:0] pmpNa4   = 2'd2;
  localparam logic [1:0] pmpNapot = 2'd3;

  // PMA attribute bit positions
  localparam int attrR = 0;
  localparam int attrW = 1;
  localparam int attrX = 2;
  localparam int attrC = 3;
  localparam int attrI = 4;
  localparam int attrA = 5;

  ////////////////////////////////////////
  // Region table: boot ROM, peripherals, RAM
  localparam int pmaRegions = 3;
  localparam logic [paBits-1:0] pmaBase [pmaRegions] =
    '{34'h0000_1000, 34'h1000_0000, 34'h8000_0000};
  localparam logic [paBits-1:0] pmaMask [pmaRegions] =
    '{34'h0000_0FFF, 34'h0003_FFFF, 34'h07FF_FFFF};
  // Bits {A, I, C, X, W, R}
  localparam logic [5:0] pmaAttr [pmaRegions] = '{6'b011101, 6'b000011, 6'b111111};

endpackage

// ==== src/tlb.sv ====
////////////////////////////////////////
// Fully associative Sv32 TLB
// Round-robin fill, flush of all entries
// Kilo and mega page translation
// Page fault checks on a hit
////////////////////////////////////////

`timescale 1ns/1ps

module tlb #(
  parameter int tlbEntries = 8
) (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      satpMode,
  input  logic [21:0]               satpPpn,
  input  logic [1:0]                effPrivilege,
  input  logic                      statusMxr,
  input  logic                      statusSum,
  input  logic                      disableTranslation,
  input  logic [mmuPkg::xLen-1:0]   address,
  input  logic                      readAccess,
  input  logic                      writeAccess,
  input  logic                      executeAccess,
  input  logic [mmuPkg::xLen-1:0]   pte,
  input  logic                      pageType,
  input  logic                      tlbWrite,
  input  logic                      tlbFlush,
  output logic [mmuPkg::paBits-1:0] tlbPAdr,
  output logic                      translate,
  output logic                      tlbHit,
  output logic                      tlbMiss,
  output logic                      tlbPageFault
);

  import mmuPkg::*;

  localparam int ptrBits = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;
  localparam logic [ptrBits-1:0] lastSlot = ptrBits'(tlbEntries - 1);

  // Entry storage
  logic [tlbEntries-1:0] entryValid;
  logic [19:0]           entryVpn   [tlbEntries];
  // Root table PPN the entry was filled under
  logic [21:0]           entryRoot  [tlbEntries];
  logic [21:0]           entryPpn   [tlbEntries];
  logic                  entryType  [tlbEntries];
  // Flags packed as {D, A, U, X, W, R}
  logic [5:0]            entryFlags [tlbEntries];
  logic [ptrBits-1:0]    replacePtr;

  // Lookup results
  logic [tlbEntries-1:0] hitVec;
  logic                  anyAccess;
  logic                  anyHit;
  logic [21:0]           hitPpn;
  logic                  hitType;
  logic [5:0]            hitFlags;
  logic                  permFault;

  ////////////////////////////////////////
  // Fill and flush
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      entryValid <= '0;
      replacePtr <= '0;
    end else begin
      if (tlbFlush) begin
        entryValid <= '0;
      end
      // A fill in the flush cycle survives
      if (tlbWrite) begin
        entryValid[replacePtr] <= 1'b1;
        replacePtr <= (replacePtr == lastSlot) ? '0 : replacePtr + 1'b1;
      end
    end
  end

  // Payload of the slot being filled
  always_ff @(posedge clk) begin
    if (tlbWrite) begin
      entryVpn[replacePtr]   <= address[31:12];
      entryRoot[replacePtr]  <= satpPpn;
      entryPpn[replacePtr]   <= pte[31:10];
      entryType[replacePtr]  <= pageType;
      entryFlags[replacePtr] <= {pte[pteD], pte[pteA], pte[pteU],
                                 pte[pteX], pte[pteW], pte[pteR]};
    end
  end

  ////////////////////////////////////////
  // Associative lookup
  ////////////////////////////////////////

  // VPN[0] only takes part for kilo pages
  for (genvar i = 0; i < tlbEntries; i++) begin : gMatch
    assign hitVec[i] = entryValid[i] && (entryRoot[i] == satpPpn) &&
                       (entryVpn[i][19:10] == address[31:22]) &&
                       ((entryType[i] == pageMega) || (entryVpn[i][9:0] == address[21:12]));
  end

  // One-hot select, so the OR picks the hitting entry
  always_comb begin
    hitPpn   = '0;
    hitType  = 1'b0;
    hitFlags = '0;
    for (int i = 0; i < tlbEntries; i++) begin
      if (hitVec[i]) begin
        hitPpn   = hitPpn | entryPpn[i];
        hitType  = hitType | entryType[i];
        hitFlags = hitFlags | entryFlags[i];
      end
    end
  end

  // Machine mode and bare mode bypass the TLB
  assign translate = satpMode && (effPrivilege != privM) && !disableTranslation;
  assign anyAccess = readAccess || writeAccess || executeAccess;
  assign anyHit    = |hitVec;
  assign tlbHit    = translate && anyAccess && anyHit;
  assign tlbMiss   = translate && anyAccess && !anyHit;

  // Mega pages keep VPN[0] as part of the offset
  assign tlbPAdr = (hitType == pageKilo) ? {hitPpn, address[11:0]} :
                                           {hitPpn[21:10], address[21:0]};

  ////////////////////////////////////////
  // Permission checks
  ////////////////////////////////////////

  assign permFault =
    ((effPrivilege == privS) && hitFlags[3] && !statusSum) ||
    ((effPrivilege == privU) && !hitFlags[3]) ||
    (executeAccess && !hitFlags[2]) ||
    // MXR makes execute-only pages readable
    (readAccess && !(hitFlags[0] || (hitFlags[2] && statusMxr))) ||
    (writeAccess && !hitFlags[1]) ||
    !hitFlags[4] ||
    (writeAccess && !hitFlags[5]);

  assign tlbPageFault = tlbHit && permFault;

  // Duplicate tags would make the OR select garbage
  assert property (@(posedge clk) disable iff (!arstN)
    (translate && anyAccess) |-> $onehot0(hitVec));

endmodule

// ==== src/pmaChecker.sv ====
////////////////////////////////////////
// Physical memory attribute checker
// Region decode from the fixed table
// Attributes and access faults
////////////////////////////////////////

`timescale 1ns/1ps

module pmaChecker (
  input  logic [mmuPkg::paBits-1:0] physicalAddress,
  input  logic                      readAccess,
  input  logic                      writeAccess,
  input  logic                      executeAccess,
  input  logic                      atomicAccess,
  output logic                      cacheable,
  output logic                      idempotent,
  output logic                      atomicAllowed,
  output logic                      pmaInstrFault,
  output logic                      pmaLoadFault,
  output logic                      pmaStoreFault,
  output logic                      pmaSquash
);

  import mmuPkg::*;

  logic [pmaRegions-1:0] regionHit;
  logic                  anyRegion;
  logic [5:0]            attr;

  // Base compare with the size bits masked off
  for (genvar i = 0; i < pmaRegions; i++) begin : gRegion
    assign regionHit[i] = (physicalAddress & ~pmaMask[i]) == pmaBase[i];
  end

  // Attributes of the matching region, zero when unmapped
  always_comb begin
    attr = '0;
    for (int i = 0; i < pmaRegions; i++) begin
      if (regionHit[i]) begin
        attr = attr | pmaAttr[i];
      end
    end
  end

  assign anyRegion     = |regionHit;
  assign cacheable     = attr[attrC];
  assign idempotent    = attr[attrI];
  assign atomicAllowed = attr[attrA];

  // Atomics count as read and write
  assign pmaInstrFault = executeAccess && (!anyRegion || !attr[attrX]);
  assign pmaLoadFault  = (readAccess || atomicAccess) && (!anyRegion || !attr[attrR]);
  assign pmaStoreFault = (writeAccess || atomicAccess) &&
                         (!anyRegion || !attr[attrW] || (atomicAccess && !attr[attrA]));

  assign pmaSquash = pmaInstrFault || pmaLoadFault || pmaStoreFault;

  // Regions in the table must not overlap
  always_comb begin
    assert ($onehot0(regionHit));
  end

endmodule

// ==== src/pmpChecker.sv ====
////////////////////////////////////////
// Physical memory protection checker
// OFF, TOR, NA4 and NAPOT matching
// Lowest entry wins, lock applies to M
////////////////////////////////////////

`timescale 1ns/1ps

module pmpChecker #(
  parameter int pmpEntries = 4
) (
  input  logic [mmuPkg::paBits-1:0]           physicalAddress,
  input  logic [1:0]                          effPrivilege,
  input  logic [8*pmpEntries-1:0]             pmpCfg,
  input  logic [mmuPkg::xLen*pmpEntries-1:0]  pmpAddr,
  input  logic                                readAccess,
  input  logic                                writeAccess,
  input  logic                                executeAccess,
  output logic                                pmpInstrFault,
  output logic                                pmpLoadFault,
  output logic                                pmpStoreFault,
  output logic                                pmpSquash
);

  import mmuPkg::*;

  // pmpaddr registers hold address bits 33:2
  logic [xLen-1:0]       paWord;
  logic [pmpEntries-1:0] entryMatch;
  logic [pmpEntries-1:0] entryOn;
  logic                  machine;
  logic                  matched;
  logic [7:0]            winCfg;
  logic                  allowR;
  logic                  allowW;
  logic                  allowX;

  assign paWord  = physicalAddress[paBits-1:2];
  assign machine = (effPrivilege == privM);

  ////////////////////////////////////////
  // Per-entry address match
  ////////////////////////////////////////

  for (genvar i = 0; i < pmpEntries; i++) begin : gEntry
    logic [7:0]      cfg;
    logic [xLen-1:0] addrWord;
    logic [xLen-1:0] lowerBound;
    logic [xLen-1:0] careMask;

    assign cfg      = pmpCfg[8*i +: 8];
    assign addrWord = pmpAddr[xLen*i +: xLen];

    // TOR lower bound comes from the previous entry
    if (i == 0) begin : gFirst
      assign lowerBound = '0;
    end else begin : gRest
      assign lowerBound = pmpAddr[xLen*(i-1) +: xLen];
    end

    // Trailing ones plus one more bit are don't care
    assign careMask = ~(addrWord ^ (addrWord + 1'b1));

    assign entryOn[i] = (cfg[cfgALo +: 2] != pmpOff);

    always_comb begin
      case (cfg[cfgALo +: 2])
        pmpTor:   entryMatch[i] = (paWord >= lowerBound) && (paWord < addrWord);
        pmpNa4:   entryMatch[i] = (paWord == addrWord);
        pmpNapot: entryMatch[i] = ((paWord ^ addrWord) & careMask) == '0;
        default:  entryMatch[i] = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Priority and permission
  ////////////////////////////////////////

  // Walk downward so the lowest match is left in winCfg
  always_comb begin
    matched = 1'b0;
    winCfg  = '0;
    for (int i = pmpEntries - 1; i >= 0; i--) begin
      if (entryMatch[i]) begin
        matched = 1'b1;
        winCfg  = pmpCfg[8*i +: 8];
      end
    end
  end

  always_comb begin
    if (matched) begin
      // Unlocked entries do not bind machine mode
      allowR = (machine && !winCfg[cfgL]) || winCfg[cfgR];
      allowW = (machine && !winCfg[cfgL]) || winCfg[cfgW];
      allowX = (machine && !winCfg[cfgL]) || winCfg[cfgX];
    end else begin
      // No match, lower modes pass only when PMP is unused
      allowR = machine || !(|entryOn);
      allowW = allowR;
      allowX = allowR;
    end
  end

  assign pmpInstrFault = executeAccess && !allowX;
  assign pmpLoadFault  = readAccess && !allowR;
  assign pmpStoreFault = writeAccess && !allowW;
  assign pmpSquash     = pmpInstrFault || pmpLoadFault || pmpStoreFault;

endmodule

// ==== src/mmu.sv ====
////////////////////////////////////////
// Memory management unit, one access port
// Effective privilege and address select
// TLB, PMA and PMP instances
// Fault and squash merge
////////////////////////////////////////

`timescale 1ns/1ps

module mmu #(
  parameter int tlbEntries = 8,
  parameter int pmpEntries = 4
) (
  input  logic                               clk,
  input  logic                               arstN,
  // Access request
  input  logic [mmuPkg::xLen-1:0]            address,
  input  logic [1:0]                         accessSize,
  input  logic                               readAccess,
  input  logic                               writeAccess,
  input  logic                               executeAccess,
  input  logic                               atomicAccess,
  // Privilege and status from the CSR file
  input  logic [1:0]                         privilegeMode,
  input  logic [mmuPkg::xLen-1:0]            satp,
  input  logic                               statusMxr,
  input  logic                               statusSum,
  input  logic                               statusMprv,
  input  logic [1:0]                         statusMpp,
  input  logic                               disableTranslation,
  // TLB fill and flush
  input  logic [mmuPkg::xLen-1:0]            pte,
  input  logic                               pageType,
  input  logic                               tlbWrite,
  input  logic                               tlbFlush,
  // PMP registers
  input  logic [8*pmpEntries-1:0]            pmpCfg,
  input  logic [mmuPkg::xLen*pmpEntries-1:0] pmpAddr,
  // Results
  output logic [mmuPkg::paBits-1:0]          physicalAddress,
  output logic                               tlbHit,
  output logic                               tlbMiss,
  output logic                               tlbPageFault,
  output logic                               instrAccessFault,
  output logic                               loadAccessFault,
  output logic                               storeAccessFault,
  output logic                               squashBusAccess,
  output logic                               cacheable,
  output logic                               idempotent,
  output logic                               atomicAllowed
);

  import mmuPkg::*;

  logic [1:0]        effPrivilege;
  logic [paBits-1:0] addressExt;
  logic [paBits-1:0] tlbPAdr;
  logic              translate;
  logic              misaligned;
  logic              pmaInstrFault;
  logic              pmaLoadFault;
  logic              pmaStoreFault;
  logic              pmaSquash;
  logic              pmpInstrFault;
  logic              pmpLoadFault;
  logic              pmpStoreFault;
  logic              pmpSquash;

  // MPRV applies to loads and stores only
  assign effPrivilege = (statusMprv && !executeAccess) ? statusMpp : privilegeMode;

  assign addressExt = {{(paBits - xLen){1'b0}}, address};

  tlb #(
    .tlbEntries(tlbEntries)
  ) uTlb (
    .clk               (clk),
    .arstN             (arstN),
    .satpMode          (satp[xLen-1]),
    .satpPpn           (satp[21:0]),
    .effPrivilege      (effPrivilege),
    .statusMxr         (statusMxr),
    .statusSum         (statusSum),
    .disableTranslation(disableTranslation),
    .address           (address),
    .readAccess        (readAccess),
    .writeAccess       (writeAccess),
    .executeAccess     (executeAccess),
    .pte               (pte),
    .pageType          (pageType),
    .tlbWrite          (tlbWrite),
    .tlbFlush          (tlbFlush),
    .tlbPAdr           (tlbPAdr),
    .translate         (translate),
    .tlbHit            (tlbHit),
    .tlbMiss           (tlbMiss),
    .tlbPageFault      (tlbPageFault)
  );

  // Translated address, else the zero-extended virtual one
  assign physicalAddress = translate ? tlbPAdr : addressExt;

  ////////////////////////////////////////
  // Physical checks
  ////////////////////////////////////////

  pmaChecker uPma (
    .physicalAddress(physicalAddress),
    .readAccess     (readAccess),
    .writeAccess    (writeAccess),
    .executeAccess  (executeAccess),
    .atomicAccess   (atomicAccess),
    .cacheable      (cacheable),
    .idempotent     (idempotent),
    .atomicAllowed  (atomicAllowed),
    .pmaInstrFault  (pmaInstrFault),
    .pmaLoadFault   (pmaLoadFault),
    .pmaStoreFault  (pmaStoreFault),
    .pmaSquash      (pmaSquash)
  );

  pmpChecker #(
    .pmpEntries(pmpEntries)
  ) uPmp (
    .physicalAddress(physicalAddress),
    .effPrivilege   (effPrivilege),
    .pmpCfg         (pmpCfg),
    .pmpAddr        (pmpAddr),
    .readAccess     (readAccess),
    .writeAccess    (writeAccess),
    .executeAccess  (executeAccess),
    .pmpInstrFault  (pmpInstrFault),
    .pmpLoadFault   (pmpLoadFault),
    .pmpStoreFault  (pmpStoreFault),
    .pmpSquash      (pmpSquash)
  );

  assign instrAccessFault = pmaInstrFault || pmpInstrFault;
  assign loadAccessFault  = pmaLoadFault || pmpLoadFault;
  assign storeAccessFault = pmaStoreFault || pmpStoreFault;
  assign squashBusAccess  = pmaSquash || pmpSquash;

  // Size 3 has no meaning on RV32
  assign misaligned = ((accessSize == 2'd1) && address[0]) ||
                      ((accessSize == 2'd2) && (address[1:0] != 2'b00)) ||
                      (accessSize == 2'd3);

  // Faults feed the trap logic every cycle
  assert property (@(posedge clk) disable iff (!arstN)
    !$isunknown({instrAccessFault, loadAccessFault, storeAccessFault}));

  // Core traps misaligned data accesses before they get here
  assert property (@(posedge clk) disable iff (!arstN)
    (readAccess || writeAccess || atomicAccess) |-> !misaligned);

endmodule

// ==== verif/mmuTb.sv ====
////////////////////////////////////////
// Testbench for the Sv32 MMU
// Clock and reset generation
// Stimulus file reader and driver
// Compare tasks and closing summary
////////////////////////////////////////

`timescale 1ns/1ps

module mmuTb;

  import mmuPkg::*;

  localparam int tlbSlots   = 4;
  localparam int pmpSlots   = 4;
  localparam int maxLines   = 200;
  localparam int resetLimit = 64;

  // DUT inputs
  logic                     clk;
  logic                     arstN;
  logic [xLen-1:0]          address;
  logic [1:0]               accessSize;
  logic                     readAccess;
  logic                     writeAccess;
  logic                     executeAccess;
  logic                     atomicAccess;
  logic [1:0]               privilegeMode;
  logic [xLen-1:0]          satp;
  logic                     statusMxr;
  logic                     statusSum;
  logic                     statusMprv;
  logic [1:0]               statusMpp;
  logic                     disableTranslation;
  logic [xLen-1:0]          pte;
  logic                     pageType;
  logic                     tlbWrite;
  logic                     tlbFlush;
  logic [8*pmpSlots-1:0]    pmpCfg;
  logic [xLen*pmpSlots-1:0] pmpAddr;

  // DUT outputs
  logic [paBits-1:0]        physicalAddress;
  logic                     tlbHit;
  logic                     tlbMiss;
  logic                     tlbPageFault;
  logic                     instrAccessFault;
  logic                     loadAccessFault;
  logic                     storeAccessFault;
  logic                     squashBusAccess;
  logic                     cacheable;
  logic                     idempotent;
  logic                     atomicAllowed;

  // Fields of the current stimulus line
  logic [3:0]               opCode;
  logic [3:0]               accBits;
  logic [1:0]               privField;
  logic                     modeBit;
  logic                     mxrBit;
  logic                     sumBit;
  logic                     disBit;
  logic [xLen-1:0]          addrField;
  logic [xLen-1:0]          pteField;
  logic                     typeBit;
  logic [8*pmpSlots-1:0]    cfgField;
  logic [xLen*pmpSlots-1:0] pmpAddrField;
  logic [paBits-1:0]        expAddr;
  logic                     fullCompare;
  // Expected {hit, miss, pageFault, instr, load, store}
  logic [5:0]               expFlags;

  int                       errorCount;
  int                       testCount;
  bit                       runFailed;

  mmu #(
    .tlbEntries(tlbSlots),
    .pmpEntries(pmpSlots)
  ) u_dut (
    .clk               (clk),
    .arstN             (arstN),
    .address           (address),
    .accessSize        (accessSize),
    .readAccess        (readAccess),
    .writeAccess       (writeAccess),
    .executeAccess     (executeAccess),
    .atomicAccess      (atomicAccess),
    .privilegeMode     (privilegeMode),
    .satp              (satp),
    .statusMxr         (statusMxr),
    .statusSum         (statusSum),
    .statusMprv        (statusMprv),
    .statusMpp         (statusMpp),
    .disableTranslation(disableTranslation),
    .pte               (pte),
    .pageType          (pageType),
    .tlbWrite          (tlbWrite),
    .tlbFlush          (tlbFlush),
    .pmpCfg            (pmpCfg),
    .pmpAddr           (pmpAddr),
    .physicalAddress   (physicalAddress),
    .tlbHit            (tlbHit),
    .tlbMiss           (tlbMiss),
    .tlbPageFault      (tlbPageFault),
    .instrAccessFault  (instrAccessFault),
    .loadAccessFault   (loadAccessFault),
    .storeAccessFault  (storeAccessFault),
    .squashBusAccess   (squashBusAccess),
    .cacheable         (cacheable),
    .idempotent        (idempotent),
    .atomicAllowed     (atomicAllowed)
  );

  ////////////////////////////////////////
  // Clock and reset
  ////////////////////////////////////////

  // 4 ns period
  always #2 clk = ~clk;

  initial begin
    clk   = 1'b0;
    arstN = 1'b0;
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkAddr(input string name, input logic [paBits-1:0] expected,
                           input logic [paBits-1:0] actual);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus handling
  ////////////////////////////////////////

  function automatic bit isCommentOrBlank(input string text);
    byte first;
    if (text.len() == 0) begin
      return 1'b1;
    end
    first = text.getc(0);
    return (first == "#") || (first == "\n") || (first == "\r");
  endfunction

  // Region attributes as {atomic, idempotent, cacheable}
  // RAM has all of them, boot ROM is cacheable and idempotent
  // Peripherals and unmapped space have none
  function automatic logic [2:0] regionAttr(input logic [paBits-1:0] addr);
    logic [2:0] attrBits;
    attrBits = 3'b000;
    if ((addr >= 34'h0_8000_0000) && (addr < 34'h0_8800_0000)) begin
      attrBits = 3'b111;
    end else if ((addr >= 34'h0_0000_1000) && (addr < 34'h0_0000_2000)) begin
      attrBits = 3'b011;
    end
    return attrBits;
  endfunction

  // Access levels only on access lines, strobes for one cycle
  task automatic driveLine;
    @(posedge clk);
    address            <= addrField;
    privilegeMode      <= privField;
    satp               <= {modeBit, {(xLen-1){1'b0}}};
    statusMxr          <= mxrBit;
    statusSum          <= sumBit;
    disableTranslation <= disBit;
    pte                <= pteField;
    pageType           <= typeBit;
    pmpCfg             <= cfgField;
    pmpAddr            <= pmpAddrField;
    tlbWrite           <= (opCode == 4'd1);
    tlbFlush           <= (opCode == 4'd2);
    readAccess         <= (opCode == 4'd0) && accBits[0];
    writeAccess        <= (opCode == 4'd0) && accBits[1];
    executeAccess      <= (opCode == 4'd0) && accBits[2];
    atomicAccess       <= (opCode == 4'd0) && accBits[3];
  endtask

  // Outputs are settled by the falling edge
  task automatic checkLine(input int lineNo);
    int         errorsBefore;
    string      opName;
    logic [2:0] expAttr;
    errorsBefore = errorCount;
    @(negedge clk);
    if (opCode == 4'd0) begin
      opName = "access";
      checkFlag("tlbHit", expFlags[5], tlbHit);
      checkFlag("tlbMiss", expFlags[4], tlbMiss);
      checkFlag("tlbPageFault", expFlags[3], tlbPageFault);
      // A miss leaves the address to the walker
      if (fullCompare) begin
        checkAddr("physicalAddress", expAddr, physicalAddress);
        checkFlag("instrAccessFault", expFlags[2], instrAccessFault);
        checkFlag("loadAccessFault", expFlags[1], loadAccessFault);
        checkFlag("storeAccessFault", expFlags[0], storeAccessFault);
        checkFlag("squashBusAccess", |expFlags[2:0], squashBusAccess);
        expAttr = regionAttr(expAddr);
        checkFlag("cacheable", expAttr[0], cacheable);
        checkFlag("idempotent", expAttr[1], idempotent);
        checkFlag("atomicAllowed", expAttr[2], atomicAllowed);
      end
    end else if (opCode == 4'd1) begin
      opName = "TLB write";
    end else begin
      opName = "TLB flush";
    end
    $display("Test %0d (line %0d) %s: %s", testCount, lineNo, opName,
             (errorCount == errorsBefore) ? "ok" : "mismatch");
  endtask

  task automatic runStimulus(input int fd);
    string lineText;
    int    lineNo;
    int    got;
    int    fields;
    lineNo = 0;
    while (!$feof(fd) && !runFailed) begin
      if (lineNo >= maxLines) begin
        $display("Stimulus reader stopped after %0d lines without reaching the end",
                 maxLines);
        runFailed = 1'b1;
      end else begin
        lineNo++;
        got = $fgets(lineText, fd);
        if (got != 0 && !isCommentOrBlank(lineText)) begin
          fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %b",
                           opCode, accBits, privField, modeBit, mxrBit, sumBit, disBit,
                           addrField, pteField, typeBit, cfgField, pmpAddrField,
                           expAddr, fullCompare, expFlags);
          if (fields != 15) begin
            $display("Line %0d of the stimulus file could not be parsed", lineNo);
            errorCount++;
          end else begin
            testCount++;
            driveLine();
            checkLine(lineNo);
          end
        end
      end
    end
  endtask

  task automatic waitForReset(output bit released);
    int waited;
    waited = 0;
    while (arstN !== 1'b1 && waited < resetLimit) begin
      @(posedge clk);
      waited++;
    end
    released = (arstN === 1'b1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : mainFlow
    int fd;
    bit released;
    // Idle inputs, word accesses, MPRV off
    address            = '0;
    accessSize         = 2'd2;
    readAccess         = 1'b0;
    writeAccess        = 1'b0;
    executeAccess      = 1'b0;
    atomicAccess       = 1'b0;
    privilegeMode      = privM;
    satp               = '0;
    statusMxr          = 1'b0;
    statusSum          = 1'b0;
    statusMprv         = 1'b0;
    statusMpp          = privU;
    disableTranslation = 1'b0;
    pte                = '0;
    pageType           = pageKilo;
    tlbWrite           = 1'b0;
    tlbFlush           = 1'b0;
    pmpCfg             = '0;
    pmpAddr            = '0;
    errorCount         = 0;
    testCount          = 0;
    runFailed          = 1'b0;

    waitForReset(released);
    if (!released) begin
      $display("Reset was not released within %0d cycles", resetLimit);
      runFailed = 1'b1;
    end else begin
      fd = $fopen("verif/mmuStimulus.txt", "r");
      if (fd == 0) begin
        $display("Stimulus file verif/mmuStimulus.txt could not be opened");
        runFailed = 1'b1;
      end else begin
        runStimulus(fd);
        $fclose(fd);
        if (testCount == 0) begin
          $display("No operations were read from the stimulus file");
          runFailed = 1'b1;
        end
      end
    end

    $display("Summary: %0d tests, %0d errors", testCount, errorCount);
    if (errorCount == 0 && !runFailed) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/mmuPkg.sv
src/tlb.sv
src/pmaChecker.sv
src/pmpChecker.sv
src/mmu.sv
verif/mmuTb.sv

// ==== Makefile ====
# Verilator simulation of the MMU testbench
TOP = mmuTb
LOG = sim.log

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/mmuStimulus.txt ====
# MMU stimulus, one operation per line; op: 0 access, 1 TLB write, 2 TLB flush
# acc: hex {atomic, exec, write, read}; prv: privilege; m x s d: satp mode, MXR, SUM, bare
# then address, pte, page type, pmpCfg, pmpAddr {3,2,1,0}, expected physical address
# full: 1 also compares the address and access faults
# last column: expected hit, miss, pageFault, instr, load and store fault bits
0 1 3 1 0 0 0 80001000 00000000 0 00000000 00000000000000000000000000000000 080001000 1 000000
0 2 1 1 0 0 1 40000000 00000000 0 00000000 00000000000000000000000000000000 040000000 1 000001
1 0 1 1 0 0 0 00400000 200040CF 0 00000000 00000000000000000000000000000000 000000000 0 000000
1 0 1 1 0 0 0 00800000 201000CF 1 00000000 00000000000000000000000000000000 000000000 0 000000
0 1 1 1 0 0 0 00400124 00000000 0 00000000 00000000000000000000000000000000 080010124 1 100000
0 1 1 1 0 0 0 008ABC10 00000000 0 00000000 00000000000000000000000000000000 0804ABC10 1 100000
0 1 1 1 0 0 0 00C00000 00000000 0 00000000 00000000000000000000000000000000 000000000 0 010000
1 0 1 1 0 0 0 00401000 200044C3 0 00000000 00000000000000000000000000000000 000000000 0 000000
1 0 1 1 0 0 0 00402000 20004847 0 00000000 00000000000000000000000000000000 000000000 0 000000
0 2 1 1 0 0 0 00401000 00000000 0 00000000 00000000000000000000000000000000 080011000 1 101000
0 2 1 1 0 0 0 00402000 00000000 0 00000000 00000000000000000000000000000000 080012000 1 101000
1 0 1 1 0 0 0 00403000 20004CC9 0 00000000 00000000000000000000000000000000 000000000 0 000000
0 1 1 1 0 0 0 00400124 00000000 0 00000000 00000000000000000000000000000000 000000000 0 010000
0 1 1 1 0 0 0 00403000 00000000 0 00000000 00000000000000000000000000000000 080013000 1 101000
0 1 1 1 1 0 0 00403000 00000000 0 00000000 00000000000000000000000000000000 080013000 1 100000
1 0 1 1 0 0 0 00404000 200050DF 0 00000000 00000000000000000000000000000000 000000000 0 000000
0 1 1 1 0 0 0 00404000 00000000 0 00000000 00000000000000000000000000000000 080014000 1 101000
2 0 1 1 0 0 0 00000000 00000000 0 00000000 00000000000000000000000000000000 000000000 0 000000
0 1 1 1 0 0 0 00401000 00000000 0 00000000 00000000000000000000000000000000 000000000 0 010000
0 1 0 0 0 0 0 80000100 00000000 0 00000019 00000000000000000000000020001FFF 080000100 1 000000
0 2 0 0 0 0 0 80000100 00000000 0 00000019 00000000000000000000000020001FFF 080000100 1 000001
0 2 3 0 0 0 0 80000100 00000000 0 00000099 00000000000000000000000020001FFF 080000100 1 000001
0 2 3 0 0 0 0 80000100 00000000 0 00000019 00000000000000000000000020001FFF 080000100 1 000000
0 1 0 0 0 0 0 80000FFC 00000000 0 00000F00 00000000000000002000080020000400 080000FFC 1 000010
0 1 0 0 0 0 0 80001000 00000000 0 00000F00 00000000000000002000080020000400 080001000 1 000000
0 1 0 0 0 0 0 80001FFC 00000000 0 00000F00 00000000000000002000080020000400 080001FFC 1 000000
0 1 0 0 0 0 0 80002000 00000000 0 00000F00 00000000000000002000080020000400 080002000 1 000010
0 8 3 0 0 0 0 10000000 00000000 0 00000000 00000000000000000000000000000000 010000000 1 000001
0 4 3 0 0 0 0 10000100 00000000 0 00000000 00000000000000000000000000000000 010000100 1 000100
